// File: Bender.yml
package:
  name: execute_unit

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/aluPkg.sv
      - hdl/satAddSub.sv
      - hdl/paddsb.sv
      - hdl/reductionAdder.sv
      - hdl/shifter.sv
      - hdl/alu.sv
      - hdl/flagRegister.sv
      - hdl/executeUnit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/executeUnitTb.sv

// File: dv/executeUnitTb.sv
`default_nettype none

`include "alu_consts.svh"

module executeUnitTb import aluPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // one op's expected outcome with flags as stored after the write
  typedef struct packed {
    word_t      result;
    flags_t     flags;
    logic [2:0] update;
  } aluExp_t;

  logic    clk;
  logic    reset;
  logic    opValid;
  word_t   opA;
  word_t   opB;
  opcode_t opcode;
  cond_t   cond;
  word_t   result;
  logic    resultValid;
  flags_t  flags;
  logic    condTrue;

  aluExp_t expQ[$];   // ops in flight
  flags_t  modelFlags; // stored flags as the model sees them
  bit      stateSeen[8];
  int      errors;
  int      checks;

  executeUnit i_dut (
    .clk(clk), .reset(reset), .opValid(opValid), .opA(opA), .opB(opB),
    .opcode(opcode), .cond(cond), .result(result), .resultValid(resultValid),
    .flags(flags), .condTrue(condTrue)
  );

  always #20 clk = ~clk; // 40 ns period

  // expected result, flags and update mask
  function automatic aluExp_t refAlu(input word_t a, input word_t b, input opcode_t op);
    aluExp_t e;
    int      s;
    int      la;
    int      lb;
    word_t   r;
    e.flags  = '0;
    e.update = 3'b010; // z only
    r        = a;
    case (op)
      `OP_ADD, `OP_SUB: begin
        if (op == `OP_ADD)
          s = int'($signed(a)) + int'($signed(b));
        else
          s = int'($signed(a)) - int'($signed(b));
        e.flags[0] = (s > 32767) || (s < -32768); // true overflow
        if (s > 32767)
          s = 32767;
        else if (s < -32768)
          s = -32768;
        e.result   = word_t'(s);
        e.flags[2] = e.result[15]; // saturated sign
        e.update   = 3'b111;
      end
      `OP_XOR: e.result = a ^ b;
      `OP_RED: begin
        s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
          + int'($signed(b[15:8])) + int'($signed(b[7:0]));
        e.result = word_t'(s); // fits in 10 bits so truncation sign extends
      end
      `OP_SLL: begin
        repeat (b[3:0]) r = {r[14:0], 1'b0};
        e.result = r;
      end
      `OP_SRA: begin
        repeat (b[3:0]) r = {r[15], r[15:1]};
        e.result = r;
      end
      `OP_ROR: begin
        repeat (b[3:0]) r = {r[0], r[15:1]};
        e.result = r;
      end
      default: begin // paddsb lanes clamp to -8..+7
        for (int i = 0; i < 4; i++) begin
          la = int'($signed(a[4*i +: 4]));
          lb = int'($signed(b[4*i +: 4]));
          s  = la + lb;
          if (s > 7)
            s = 7;
          else if (s < -8)
            s = -8;
          e.result[4*i +: 4] = s[3:0];
        end
      end
    endcase
    e.flags[1] = (e.result == '0);
    return e;
  endfunction

  task automatic refCond(input flags_t f, input cond_t c, output logic t);
    logic n;
    logic z;
    logic v;
    {n, z, v} = f;
    case (c)
      `COND_NEQ:  t = !z;
      `COND_EQ:   t = z;
      `COND_GT:   t = !z && !n;
      `COND_LT:   t = n;
      `COND_GTE:  t = z || !n;
      `COND_LTE:  t = n || z;
      `COND_OVFL: t = v;
      default:    t = 1'b1;
    endcase
  endtask

  task automatic checkValue(input string what, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // drive one op 2 ns after the edge
  task automatic issueOp(input word_t a, input word_t b, input opcode_t op);
    aluExp_t e;
    @(posedge clk);
    #2;
    opValid = 1'b1;
    opA     = a;
    opB     = b;
    opcode  = op;
    cond    = cond_t'($urandom);
    e       = refAlu(a, b, op);
    for (int i = 0; i < 3; i++)
      if (e.update[i])
        modelFlags[i] = e.flags[i]; // bits not updated keep their old value
    e.flags = modelFlags;
    expQ.push_back(e);
  endtask

  task automatic idleCycle(input cond_t c);
    @(posedge clk);
    #2;
    opValid = 1'b0;
    opA     = word_t'($urandom); // junk the dut must ignore
    opB     = word_t'($urandom);
    cond    = c;
  endtask

  // walk all conditions once per new flag state
  task automatic sweepIfNew();
    if (!stateSeen[modelFlags]) begin
      stateSeen[modelFlags] = 1'b1;
      for (int c = 0; c < 8; c++)
        idleCycle(cond_t'(c));
    end
  endtask

  task automatic runOp(input word_t a, input word_t b, input opcode_t op);
    issueOp(a, b, op);
    sweepIfNew();
  endtask

  // samples at the falling edge between input and register updates
  initial begin : compareOutputs
    aluExp_t rec;
    word_t   expResult;
    flags_t  expFlags;
    logic    expCond;
    logic    lastOpValid;
    expResult   = '0;
    expFlags    = '0;
    lastOpValid = 1'b0;
    @(posedge clk); // first reset edge
    forever begin
      @(negedge clk);
      checkValue("resultValid", resultValid, lastOpValid); // latency of one
      if (resultValid === 1'b1) begin
        if (expQ.size() == 0) begin
          errors++;
          $display("resultValid went high at %0t ns with no operation in flight", $time);
        end else begin
          rec       = expQ.pop_front();
          expResult = rec.result;
          expFlags  = rec.flags;
        end
      end
      checkValue("result", result, expResult); // held when idle
      checkValue("flags", flags, expFlags);
      refCond(expFlags, cond, expCond);
      checkValue("condTrue", condTrue, expCond);
      lastOpValid = opValid;
    end
  end

  initial begin : mainSequence
    int drain;
    clk        = 1'b0;
    reset      = 1'b1;
    opValid    = 1'b0;
    opA        = '0;
    opB        = '0;
    opcode     = '0;
    cond       = '0;
    errors     = 0;
    checks     = 0;
    modelFlags = '0;
    void'($urandom(32'haef8));
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    sweepIfNew(); // reset state
    // saturating add/sub corners
    runOp(16'h7FFF, 16'h0001, `OP_ADD);
    runOp(16'h8000, 16'h0001, `OP_SUB);
    runOp(16'h8000, 16'hFFFF, `OP_ADD);
    runOp(16'h7FFF, 16'hFFFF, `OP_SUB);
    runOp(16'h1234, 16'h0100, `OP_ADD); // v clears
    runOp(16'h0005, 16'h0009, `OP_SUB); // negative, no overflow
    runOp(16'h0003, 16'h0003, `OP_SUB); // zero
    // n and v must survive non-arithmetic ops
    runOp(16'h7FFF, 16'h7FFF, `OP_ADD);
    runOp(16'hA5A5, 16'hA5A5, `OP_XOR);
    runOp(16'h8001, 16'h0004, `OP_SLL);
    runOp(16'h8000, 16'h0010, `OP_SLL); // amount uses low 4 bits only
    runOp(16'h8080, 16'h8080, `OP_RED); // most negative total
    runOp(16'h7F7F, 16'h7F7F, `OP_RED);
    runOp(16'h7777, 16'h1111, `OP_PADDSB); // all lanes clamp high
    runOp(16'h8888, 16'h8888, `OP_PADDSB); // all lanes clamp low
    runOp(16'h8000, 16'h8000, `OP_ADD);
    runOp(16'h0000, 16'h0000, `OP_ROR);
    repeat (3) idleCycle(cond_t'($urandom));
    // shifts by every amount
    for (int op = `OP_SLL; op <= `OP_ROR; op++)
      for (int amt = 0; amt < 16; amt++)
        runOp(word_t'($urandom), {12'($urandom), 4'(amt)}, opcode_t'(op));
    repeat (500) runOp(word_t'($urandom), word_t'($urandom), opcode_t'($urandom));
    repeat (4) idleCycle(cond_t'($urandom));
    for (drain = 0; drain < 20 && expQ.size() != 0; drain++)
      @(posedge clk);
    if (expQ.size() != 0) begin
      errors++;
      $display("timed out with %0d results never returned", expQ.size());
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none

`include "alu_consts.svh"

module alu import aluPkg::*; (
  input  word_t      a,
  input  word_t      b,
  input  opcode_t    opcode,
  output word_t      result,
  output flags_t     flags,      // {n, z, v}
  output logic [2:0] flagUpdate  // write enables, same order as flags
);

  word_t addSubSum;
  word_t xorResult;
  word_t redResult;
  word_t shiftResult;
  word_t paddsbSum;
  logic  posOvfl;
  logic  negOvfl;
  logic  isAddSub; // add or sub, the only ops touching n and v

  assign isAddSub = (opcode == `OP_ADD) | (opcode == `OP_SUB);

  satAddSub iAddSub (
    .a       (a),
    .b       (b),
    .sub     (opcode == `OP_SUB),
    .sum     (addSubSum),
    .posOvfl (posOvfl),
    .negOvfl (negOvfl)
  );

  paddsb iPaddsb (.a(a), .b(b), .sum(paddsbSum));

  reductionAdder iRed (.a(a), .b(b), .sum(redResult));

  // opcode low bits line up with the shifter modes for sll, sra, ror
  shifter iShift (
    .shiftIn  (a),
    .shiftVal (b[3:0]),
    .mode     (opcode[1:0]),
    .shiftOut (shiftResult)
  );

  assign xorResult = a ^ b;

  always_comb begin
    case (opcode)
      `OP_ADD, `OP_SUB:          result = addSubSum;
      `OP_XOR:                   result = xorResult;
      `OP_RED:                   result = redResult;
      `OP_SLL, `OP_SRA, `OP_ROR: result = shiftResult;
      default:                   result = paddsbSum; // OP_PADDSB
    endcase
  end

  // n is the saturated sign, v reports the true overflow
  assign flags = {addSubSum[15], (result == '0), (posOvfl | negOvfl)};

  // z always written, n and v only by add/sub
  assign flagUpdate = {isAddSub, 1'b1, isAddSub};

endmodule

`default_nettype wire

// File: hdl/aluPkg.sv
`default_nettype none

`include "alu_consts.svh"

package aluPkg;

  // one operand or result word
  typedef logic [`DATA_WIDTH-1:0] word_t;

  typedef logic [2:0] opcode_t; // alu opcode, see OP_* values
  typedef logic [2:0] cond_t;   // branch condition, see COND_* values

  // stored processor flags, msb first
  // bit 2 = N, bit 1 = Z, bit 0 = V
  typedef logic [2:0] flags_t;

endpackage

`default_nettype wire

// File: hdl/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result width
`define DATA_WIDTH 16

// alu opcodes, the shifts share the low two bits with the shifter mode
`define OP_ADD    3'd0
`define OP_SUB    3'd1
`define OP_XOR    3'd2
`define OP_RED    3'd3
`define OP_SLL    3'd4
`define OP_SRA    3'd5
`define OP_ROR    3'd6
`define OP_PADDSB 3'd7

// branch condition codes, evaluated on the stored flags
`define COND_NEQ    3'd0
`define COND_EQ     3'd1
`define COND_GT     3'd2
`define COND_LT     3'd3
`define COND_GTE    3'd4
`define COND_LTE    3'd5
`define COND_OVFL   3'd6
`define COND_UNCOND 3'd7

`endif

// File: hdl/executeUnit.sv
`default_nettype none

module executeUnit import aluPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    opValid,     // operands and opcode valid this cycle
  input  word_t   opA,
  input  word_t   opB,
  input  opcode_t opcode,
  input  cond_t   cond,        // branch condition to test
  output word_t   result,
  output logic    resultValid, // one cycle pulse per op
  output flags_t  flags,
  output logic    condTrue
);

  word_t      aluResult;
  flags_t     aluFlags;
  logic [2:0] flagUpdate;

  alu iAlu (
    .a          (opA),
    .b          (opB),
    .opcode     (opcode),
    .result     (aluResult),
    .flags      (aluFlags),
    .flagUpdate (flagUpdate)
  );

  // single pipeline stage, a new op can enter every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      result      <= '0;
      resultValid <= 1'b0;
    end else begin
      resultValid <= opValid;
      if (opValid)
        result <= aluResult; // hold across idle cycles
    end
  end

  // flags land on the same edge as the result
  flagRegister iFlags (
    .clk        (clk),
    .reset      (reset),
    .write      (opValid),
    .flagsIn    (aluFlags),
    .flagUpdate (flagUpdate),
    .cond       (cond),
    .flags      (flags),
    .condTrue   (condTrue)
  );

endmodule

`default_nettype wire

// File: hdl/flagRegister.sv
`default_nettype none

`include "alu_consts.svh"

module flagRegister import aluPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       write,      // one op completes this edge
  input  flags_t     flagsIn,
  input  logic [2:0] flagUpdate, // per-bit write mask
  input  cond_t      cond,
  output flags_t     flags,      // stored {n, z, v}
  output logic       condTrue
);

  logic n;
  logic z;
  logic v;

  always_ff @(posedge clk) begin
    if (reset)
      flags <= '0;
    else if (write)
      flags <= (flagUpdate & flagsIn) | (~flagUpdate & flags); // masked merge
  end

  assign {n, z, v} = flags;

  // condition decode on the stored bits only
  always_comb begin
    case (cond)
      `COND_NEQ:  condTrue = ~z;
      `COND_EQ:   condTrue = z;
      `COND_GT:   condTrue = ~z & ~n;
      `COND_LT:   condTrue = n;
      `COND_GTE:  condTrue = z | ~n;
      `COND_LTE:  condTrue = n | z;
      `COND_OVFL: condTrue = v;
      default:    condTrue = 1'b1; // unconditional
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/paddsb.sv
`default_nettype none

module paddsb import aluPkg::*; (
  input  word_t a,
  input  word_t b,
  output word_t sum
);

  // four independent nibble lanes, no carry crosses a lane boundary
  for (genvar i = 0; i < 4; i++) begin : gLane
    logic [3:0] laneA;
    logic [3:0] laneB;
    logic [3:0] laneRaw; // wrapped lane sum
    logic       lanePos; // lane went past +7
    logic       laneNeg; // lane went past -8

    assign laneA   = a[4*i +: 4];
    assign laneB   = b[4*i +: 4];
    assign laneRaw = laneA + laneB;

    // same sign in, other sign out
    assign lanePos = ~laneA[3] & ~laneB[3] &  laneRaw[3];
    assign laneNeg =  laneA[3] &  laneB[3] & ~laneRaw[3];

    assign sum[4*i +: 4] = lanePos ? 4'h7 :
                           laneNeg ? 4'h8 :
                           laneRaw;
  end

endmodule

`default_nettype wire

// File: hdl/reductionAdder.sv
`default_nettype none

module reductionAdder import aluPkg::*; (
  input  word_t a,
  input  word_t b,
  output word_t sum
);

  logic [9:0] byteAH; // each byte sign extended to the total width
  logic [9:0] byteAL;
  logic [9:0] byteBH;
  logic [9:0] byteBL;
  logic [9:0] pairA;  // a high + a low
  logic [9:0] pairB;  // b high + b low
  logic [9:0] total;

  assign byteAH = {{2{a[15]}}, a[15:8]};
  assign byteAL = {{2{a[7]}},  a[7:0]};
  assign byteBH = {{2{b[15]}}, b[15:8]};
  assign byteBL = {{2{b[7]}},  b[7:0]};

  // two level tree, 10 bits hold -512..+508 so nothing wraps
  assign pairA = byteAH + byteAL;
  assign pairB = byteBH + byteBL;
  assign total = pairA + pairB;

  // no saturation, just widen to a full word
  assign sum = {{6{total[9]}}, total};

endmodule

`default_nettype wire

// File: hdl/satAddSub.sv
`default_nettype none

module satAddSub import aluPkg::*; (
  input  word_t a,
  input  word_t b,
  input  logic  sub,     // 1 = a - b
  output word_t sum,
  output logic  posOvfl, // true sum above 16'h7FFF
  output logic  negOvfl  // true sum below 16'h8000
);

  word_t bEff; // b or its ones complement
  word_t raw;  // wrapped sum before clamping

  // subtract as a + ~b + 1, carry-in is the sub bit
  assign bEff = sub ? ~b : b;
  assign raw  = a + bEff + word_t'(sub);

  // overflow only when both inputs share a sign and the result flips it
  assign posOvfl = ~a[15] & ~bEff[15] &  raw[15];
  assign negOvfl =  a[15] &  bEff[15] & ~raw[15];

  always_comb begin
    if (posOvfl)
      sum = 16'h7FFF; // clamp to max positive
    else if (negOvfl)
      sum = 16'h8000; // clamp to max negative
    else
      sum = raw;
  end

endmodule

`default_nettype wire

// File: hdl/shifter.sv
`default_nettype none

module shifter import aluPkg::*; (
  input  word_t      shiftIn,
  input  logic [3:0] shiftVal, // shift amount 0..15
  input  logic [1:0] mode,     // 0 sll, 1 sra, 2 ror
  output word_t      shiftOut
);

  word_t stage1; // after the 1 bit stage
  word_t stage2; // after the 2 bit stage
  word_t stage4; // after the 4 bit stage

  // one fixed-distance step of the log shifter
  function automatic word_t shiftStage(
    input word_t       din,
    input logic [1:0]  stepMode,
    input int unsigned amt
  );
    case (stepMode)
      2'd0:    shiftStage = din << amt;                    // zero fill
      2'd1:    shiftStage = word_t'($signed(din) >>> amt); // sign fill
      2'd2:    shiftStage = (din >> amt) | (din << (16 - amt));
      default: shiftStage = din; // mode 3 not used by the alu
    endcase
  endfunction

  // each bit of shiftVal enables one stage
  assign stage1   = shiftVal[0] ? shiftStage(shiftIn, mode, 1) : shiftIn;
  assign stage2   = shiftVal[1] ? shiftStage(stage1, mode, 2) : stage1;
  assign stage4   = shiftVal[2] ? shiftStage(stage2, mode, 4) : stage2;
  assign shiftOut = shiftVal[3] ? shiftStage(stage4, mode, 8) : stage4;

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/aluPkg.sv
hdl/satAddSub.sv
hdl/paddsb.sv
hdl/reductionAdder.sv
hdl/shifter.sv
hdl/alu.sv
hdl/flagRegister.sv
hdl/executeUnit.sv
dv/executeUnitTb.sv
